// ==== include/soc_config.svh ====
`ifndef SOC_CONFIG_SVH
`define SOC_CONFIG_SVH

// master port
`define SOC_ADDR_W 16
`define SOC_DATA_W 32

// upper address bits pick the region
`define SOC_REGION_W 2
`define SOC_N_SLAVES 4

// slave and region indices
`define SLAVE_MAIN 0
`define SLAVE_BOOT 1
`define SLAVE_UART 2
`define SLAVE_RST  3

// word address widths of the RAMs
`define SOC_BOOT_WORDS_W 8
`define SOC_MAIN_WORDS_W 10

// serial bit period in clock cycles
`define SOC_UART_BIT_CYCLES 8

`endif

// ==== source/soc_pkg.sv ====
`default_nettype none

`include "soc_config.svh"

package soc_pkg;

   typedef logic [`SOC_ADDR_W-1:0] addr_t;
   typedef logic [`SOC_DATA_W-1:0] data_t;

   // one bit per byte, all zero for a read
   typedef logic [3:0] strb_t;

   typedef logic [`SOC_N_SLAVES-1:0] slave_sel_t;

   // master side, held until ready
   typedef struct packed {
      logic  valid;
      addr_t addr;
      data_t wdata;
      strb_t wstrb;
   } bus_req_t;

   // rdata only meaningful with ready
   typedef struct packed {
      logic  ready;
      data_t rdata;
   } bus_rsp_t;

endpackage

`default_nettype wire

// ==== source/soc_interconnect.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "soc_config.svh"

module soc_interconnect
   import soc_pkg::*;
(
   input  bus_req_t   req,
   input  logic       boot,
   input  bus_rsp_t   slave_rsp [`SOC_N_SLAVES],
   output slave_sel_t sel,
   output bus_rsp_t   rsp
);

   logic [`SOC_REGION_W-1:0] region;
   logic [`SOC_REGION_W-1:0] target;
   slave_sel_t               ready_vec;

   assign region = req.addr[`SOC_ADDR_W-1 -: `SOC_REGION_W];

   // region 0 is the boot RAM until software clears boot
   always_comb begin
      if (boot && region == `SOC_REGION_W'(`SLAVE_MAIN)) begin
         target = `SOC_REGION_W'(`SLAVE_BOOT);
      end else begin
         target = region;
      end
   end

   always_comb begin
      sel = '0;
      sel[target] = req.valid;
   end

   // answer of the addressed slave goes back to the master
   assign rsp = slave_rsp[target];

   always_comb begin
      for (int i = 0; i < `SOC_N_SLAVES; i++) begin
         ready_vec[i] = slave_rsp[i].ready;
      end
   end

   // two slaves answering at once means a decode or handshake fault
   always_comb begin
      assert final ($onehot0(ready_vec))
         else $error("soc_interconnect: several slaves ready at once (%b)", ready_vec);
   end

endmodule

`default_nettype wire

// ==== source/soc_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module soc_ram
   import soc_pkg::*;
#(
   parameter int WORDS_W = 8
)(
   input  logic     clk,
   input  logic     reset,
   input  logic     sel,
   input  bus_req_t req,
   output bus_rsp_t rsp
);

   localparam int DEPTH = 1 << WORDS_W;

   data_t              mem [DEPTH];
   logic [WORDS_W-1:0] word_addr;
   logic               take;
   logic               ready;
   data_t              rdata;

   // byte address bits dropped, upper bits wrap
   assign word_addr = req.addr[WORDS_W+1:2];

   assign take = sel && req.valid && !ready;

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         ready <= 1'b0;
      end else begin
         ready <= take;
      end
   end

   always_ff @(posedge clk) begin
      if (take) begin
         for (int b = 0; b < 4; b++) begin
            if (req.wstrb[b]) begin
               mem[word_addr][8*b +: 8] <= req.wdata[8*b +: 8];
            end
         end
         rdata <= mem[word_addr];
      end
   end

   assign rsp = '{ready: ready, rdata: rdata};

   // one acknowledge per held request
   assert property (@(posedge clk) disable iff (reset) ready |=> !ready)
      else $error("soc_ram: ready high on two consecutive cycles");

endmodule

`default_nettype wire

// ==== source/soc_uart_tx.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "soc_config.svh"

module soc_uart_tx
   import soc_pkg::*;
(
   input  logic     clk,
   input  logic     reset,
   input  logic     sel,
   input  bus_req_t req,
   input  logic     cts,
   output bus_rsp_t rsp,
   output logic     txd
);

   localparam int CNT_W = $clog2(`SOC_UART_BIT_CYCLES + 1);

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_START,
      ST_DATA,
      ST_STOP
   } tx_state_t;

   tx_state_t  state;
   logic [CNT_W-1:0] bit_cnt;
   logic [2:0] bit_idx;
   logic [7:0] shift;
   logic       pending;
   logic       busy;
   logic       bit_end;
   logic       data_write;
   logic       take;
   logic       ready;
   data_t      rdata;

   assign busy = pending || state != ST_IDLE;
   assign bit_end = bit_cnt == CNT_W'(`SOC_UART_BIT_CYCLES - 1);

   // word 0 write is the byte to send, held off while busy
   assign data_write = |req.wstrb && !req.addr[2];
   assign take = sel && req.valid && !ready && !(data_write && busy);

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         ready   <= 1'b0;
         state   <= ST_IDLE;
         bit_cnt <= '0;
         bit_idx <= '0;
         pending <= 1'b0;
         txd     <= 1'b1;
      end else begin
         ready <= take;
         if (take && data_write) begin
            pending <= 1'b1;
         end
         case (state)
            ST_IDLE: begin
               txd <= 1'b1;
               if (pending && cts) begin
                  state   <= ST_START;
                  txd     <= 1'b0;
                  bit_cnt <= '0;
                  pending <= 1'b0;
               end
            end
            ST_START: begin
               bit_cnt <= bit_end ? '0 : bit_cnt + 1'b1;
               if (bit_end) begin
                  state   <= ST_DATA;
                  bit_idx <= '0;
                  txd     <= shift[0];
               end
            end
            ST_DATA: begin
               bit_cnt <= bit_end ? '0 : bit_cnt + 1'b1;
               if (bit_end) begin
                  if (bit_idx == 3'd7) begin
                     state <= ST_STOP;
                     txd   <= 1'b1;
                  end else begin
                     bit_idx <= bit_idx + 1'b1;
                     txd     <= shift[0];
                  end
               end
            end
            default: begin
               bit_cnt <= bit_end ? '0 : bit_cnt + 1'b1;
               if (bit_end) begin
                  state <= ST_IDLE;
               end
            end
         endcase
      end
   end

   // next data bit sits in bit 0
   always_ff @(posedge clk) begin
      if (take && data_write) begin
         shift <= req.wdata[7:0];
      end else if (bit_end && (state == ST_START || state == ST_DATA)) begin
         shift <= shift >> 1;
      end
      if (take) begin
         rdata <= req.addr[2] ? data_t'(busy) : '0;
      end
   end

   assign rsp = '{ready: ready, rdata: rdata};

   assert property (@(posedge clk) disable iff (reset) state == ST_IDLE |-> txd)
      else $error("soc_uart_tx: line low while idle");

endmodule

`default_nettype wire

// ==== source/soc_reset_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module soc_reset_ctrl
   import soc_pkg::*;
(
   input  logic     clk,
   input  logic     reset,
   input  logic     sel,
   input  bus_req_t req,
   output bus_rsp_t rsp,
   output logic     boot,
   output logic     core_reset
);

   logic  take;
   logic  is_write;
   logic  ready;
   data_t rdata;

   assign take = sel && req.valid && !ready;
   assign is_write = |req.wstrb;

   // reads are acknowledged too
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         ready      <= 1'b0;
         boot       <= 1'b1;
         core_reset <= 1'b0;
      end else begin
         ready      <= take;
         core_reset <= take && is_write && req.wdata[0];
         if (take && is_write) begin
            boot <= req.wdata[1];
         end
      end
   end

   // boot flag in bit 1
   always_ff @(posedge clk) begin
      if (take) begin
         rdata    <= '0;
         rdata[1] <= boot;
      end
   end

   assign rsp = '{ready: ready, rdata: rdata};

endmodule

`default_nettype wire

// ==== source/soc_system.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "soc_config.svh"

module soc_system
   import soc_pkg::*;
(
   input  logic     clk,
   input  logic     reset,
   input  bus_req_t req,
   input  logic     uart_cts,
   output bus_rsp_t rsp,
   output logic     uart_txd,
   output logic     core_reset
);

   slave_sel_t sel;
   bus_rsp_t   slave_rsp [`SOC_N_SLAVES];
   logic       boot;

   soc_interconnect u_interconnect (
      .req       (req),
      .boot      (boot),
      .slave_rsp (slave_rsp),
      .sel       (sel),
      .rsp       (rsp)
   );

   // firmware RAM behind region 0 once boot is cleared
   soc_ram #(
      .WORDS_W (`SOC_MAIN_WORDS_W)
   ) u_main_ram (
      .clk   (clk),
      .reset (reset),
      .sel   (sel[`SLAVE_MAIN]),
      .req   (req),
      .rsp   (slave_rsp[`SLAVE_MAIN])
   );

   soc_ram #(
      .WORDS_W (`SOC_BOOT_WORDS_W)
   ) u_boot_ram (
      .clk   (clk),
      .reset (reset),
      .sel   (sel[`SLAVE_BOOT]),
      .req   (req),
      .rsp   (slave_rsp[`SLAVE_BOOT])
   );

   soc_uart_tx u_uart_tx (
      .clk   (clk),
      .reset (reset),
      .sel   (sel[`SLAVE_UART]),
      .req   (req),
      .cts   (uart_cts),
      .rsp   (slave_rsp[`SLAVE_UART]),
      .txd   (uart_txd)
   );

   soc_reset_ctrl u_reset_ctrl (
      .clk        (clk),
      .reset      (reset),
      .sel        (sel[`SLAVE_RST]),
      .req        (req),
      .rsp        (slave_rsp[`SLAVE_RST]),
      .boot       (boot),
      .core_reset (core_reset)
   );

endmodule

`default_nettype wire

// ==== testbench/tb_soc_system.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "soc_config.svh"

module tb_soc_system
   import soc_pkg::*;
();

   localparam int BIT = `SOC_UART_BIT_CYCLES;
   localparam int FRAME = 10 * BIT;
   localparam int BUS = 3;
   localparam int N_RAM = 40;
   localparam int N_ALIAS = 8;
   localparam int N_MAIN = 16;
   localparam int N_UART = 6;
   localparam int HOLD = 4 * BIT;
   // worst-case cycles per test from bus ops and serial frames
   localparam int T1 = 2 * BUS + 8;
   localparam int T2 = N_RAM * BUS;
   localparam int T3 = (4 * N_ALIAS + 2 + 3 * N_MAIN) * BUS;
   localparam int T4 = 4 * BUS + 8;
   localparam int T5 = (N_UART + 2) * BUS + (N_UART + 1) * FRAME + BIT;
   localparam int T6 = HOLD + 3 * BUS + 3 * FRAME;
   localparam int LIMIT = 64 + 2 * (T1 + T2 + T3 + T4 + T5 + T6);

   localparam int SHIFT = `SOC_ADDR_W - `SOC_REGION_W;
   localparam addr_t UART_DATA = addr_t'(`SLAVE_UART) << SHIFT;
   localparam addr_t UART_STAT = UART_DATA | addr_t'(4);
   localparam addr_t RST_ADDR = addr_t'(`SLAVE_RST) << SHIFT;

   logic     clk;
   logic     reset;
   bus_req_t req;
   logic     uart_cts;
   bus_rsp_t rsp;
   logic     uart_txd;
   logic     core_reset;

   // reference model
   data_t      boot_mem [2**`SOC_BOOT_WORDS_W];
   strb_t      boot_vld [2**`SOC_BOOT_WORDS_W];
   data_t      main_mem [2**`SOC_MAIN_WORDS_W];
   strb_t      main_vld [2**`SOC_MAIN_WORDS_W];
   logic       boot_flag;
   logic [7:0] exp_bytes [$];

   int         frames_done;
   int         pulse_cycles;
   int         errors;
   int         err_mark;
   int         tests_failed;
   int         cycle_count;
   int         idx;
   int         base;
   int         lat;
   data_t      rd;
   logic [7:0] rx_byte;
   logic [7:0] tx_byte;
   logic [7:0] tx_byte2;
   logic       boot_bit;

   soc_system u_soc_system (
      .clk        (clk),
      .reset      (reset),
      .req        (req),
      .uart_cts   (uart_cts),
      .rsp        (rsp),
      .uart_txd   (uart_txd),
      .core_reset (core_reset)
   );

   always #4 clk = ~clk;

   initial begin
      cycle_count = 0;
      while (cycle_count < LIMIT) begin
         @(posedge clk);
         cycle_count++;
      end
      $display("timeout: run still going after %0d clock cycles", LIMIT);
      $display("*** TEST FAILED ***");
      $finish;
   end

   function automatic data_t byte_mask(input strb_t s);
      data_t m;
      for (int b = 0; b < 4; b++) m[8*b +: 8] = {8{s[b]}};
      return m;
   endfunction

   // random upper bits exercise the address wrap
   function automatic addr_t ram_addr(input int region, input int word);
      addr_t a;
      a = addr_t'($urandom) << 2;
      a[`SOC_ADDR_W-1 -: `SOC_REGION_W] = `SOC_REGION_W'(region);
      a[`SOC_MAIN_WORDS_W+1:2] = `SOC_MAIN_WORDS_W'(word);
      return a;
   endfunction

   task automatic note_failure(input string msg);
      $display("%s", msg);
      errors++;
   endtask

   task automatic compare_word(input string name, input data_t expected, input data_t actual);
      assert (actual === expected)
         else begin
            $display("Error %s: expected %h, actual %h", name, expected, actual);
            errors++;
         end
   endtask

   task automatic drive_req(input addr_t addr, input data_t wdata, input strb_t wstrb);
      @(negedge clk);
      req = '{valid: 1'b1, addr: addr, wdata: wdata, wstrb: wstrb};
   endtask

   task automatic wait_ready(output data_t rdata, output int latency);
      latency = 0;
      do begin
         @(negedge clk);
         latency++;
      end while (rsp.ready !== 1'b1);
      rdata = rsp.rdata;
      // request stays up across the edge that takes ready
      @(negedge clk);
      req = '0;
   endtask

   task automatic bus_op(input addr_t addr, input data_t wdata, input strb_t wstrb,
                         output data_t rdata, output int latency);
      drive_req(addr, wdata, wstrb);
      wait_ready(rdata, latency);
   endtask

   // route by region and boot flag then check or update the model
   task automatic ram_access(input string name, input addr_t addr, input data_t wdata,
                             input strb_t wstrb);
      logic [`SOC_REGION_W-1:0] region;
      logic  to_boot;
      int    word;
      data_t rdata;
      int    latency;
      data_t mask;
      region = addr[`SOC_ADDR_W-1 -: `SOC_REGION_W];
      to_boot = region == `SLAVE_BOOT || (region == `SLAVE_MAIN && boot_flag);
      word = to_boot ? int'(addr[`SOC_BOOT_WORDS_W+1:2]) : int'(addr[`SOC_MAIN_WORDS_W+1:2]);
      bus_op(addr, wdata, wstrb, rdata, latency);
      compare_word({name, " latency"}, 1, latency);
      if (wstrb != '0) begin
         for (int b = 0; b < 4; b++) begin
            if (wstrb[b] && to_boot) boot_mem[word][8*b +: 8] = wdata[8*b +: 8];
            else if (wstrb[b]) main_mem[word][8*b +: 8] = wdata[8*b +: 8];
         end
         if (to_boot) boot_vld[word] = boot_vld[word] | wstrb;
         else main_vld[word] = main_vld[word] | wstrb;
      end else if (to_boot) begin
         mask = byte_mask(boot_vld[word]);
         compare_word(name, boot_mem[word] & mask, rdata & mask);
      end else begin
         mask = byte_mask(main_vld[word]);
         compare_word(name, main_mem[word] & mask, rdata & mask);
      end
   endtask

   task automatic check_boot(input string name);
      data_t rdata;
      int    latency;
      bus_op(RST_ADDR, '0, '0, rdata, latency);
      compare_word(name, data_t'(boot_flag) << 1, rdata & 32'h2);
   endtask

   task automatic finish_test(input string name);
      if (errors == err_mark) begin
         $display("%s: ok", name);
      end else begin
         $display("%s: %0d failed checks", name, errors - err_mark);
         tests_failed++;
      end
      err_mark = errors;
   endtask

   // pre-edge values while the request is still held
   always @(posedge clk) begin
      if (!reset && core_reset === 1'b1) begin
         pulse_cycles++;
         assert (rsp.ready === 1'b1)
            else note_failure("core_reset went high without a bus ready");
      end
   end

   // serial monitor sampling mid-bit
   always begin
      @(negedge clk);
      if (!reset && uart_txd === 1'b0) begin
         repeat (BIT / 2 - 1) @(negedge clk);
         assert (uart_txd === 1'b0) else note_failure("uart start bit ended too early");
         for (int i = 0; i < 8; i++) begin
            repeat (BIT) @(negedge clk);
            rx_byte[i] = uart_txd;
         end
         repeat (BIT) @(negedge clk);
         assert (uart_txd === 1'b1) else note_failure("uart stop bit missing");
         assert (exp_bytes.size() != 0)
            else note_failure("uart sent a frame with no byte written");
         if (exp_bytes.size() != 0) begin
            compare_word("uart frame", data_t'(exp_bytes.pop_front()), data_t'(rx_byte));
         end
         frames_done++;
      end
   end

   initial begin
      void'($urandom(32'hd35e_9df9));
      clk = 1'b0;
      reset = 1'b1;
      req = '0;
      uart_cts = 1'b1;
      boot_flag = 1'b1;
      frames_done = 0;
      pulse_cycles = 0;
      errors = 0;
      err_mark = 0;
      tests_failed = 0;
      foreach (boot_vld[i]) boot_vld[i] = '0;
      foreach (main_vld[i]) main_vld[i] = '0;
      repeat (5) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;

      @(negedge clk);
      assert (rsp.ready === 1'b0 && core_reset === 1'b0 && uart_txd === 1'b1)
         else note_failure("test 1: outputs not at their reset values");
      check_boot("test 1 boot flag");
      finish_test("test 1 reset values");

      for (int n = 0; n < N_RAM; n++) begin
         idx = $urandom_range(0, 15);
         if ($urandom_range(0, 2) == 0)
            ram_access("test 2 boot read", ram_addr(`SLAVE_BOOT, idx), '0, '0);
         else
            ram_access("test 2 boot write", ram_addr(`SLAVE_BOOT, idx), $urandom,
                       strb_t'($urandom_range(1, 15)));
      end
      finish_test("test 2 boot RAM strobes");

      // region 0 and region 1 name the same words while boot is set
      for (int n = 0; n < N_ALIAS; n++) begin
         idx = $urandom_range(0, 15);
         ram_access("test 3 alias write", ram_addr(`SLAVE_MAIN, idx), $urandom, 4'hf);
         ram_access("test 3 alias read", ram_addr(`SLAVE_BOOT, idx), '0, '0);
         idx = $urandom_range(0, 15);
         ram_access("test 3 alias write", ram_addr(`SLAVE_BOOT, idx), $urandom, 4'hf);
         ram_access("test 3 alias read", ram_addr(`SLAVE_MAIN, idx), '0, '0);
      end
      bus_op(RST_ADDR, '0, 4'hf, rd, lat);
      boot_flag = 1'b0;
      check_boot("test 3 boot flag");
      for (int n = 0; n < N_MAIN; n++)
         ram_access("test 3 main write", ram_addr(`SLAVE_MAIN, n), $urandom, 4'hf);
      for (int n = 0; n < N_MAIN; n++)
         ram_access("test 3 main read", ram_addr(`SLAVE_MAIN, n), '0, '0);
      for (int n = 0; n < N_MAIN; n++)
         ram_access("test 3 boot read", ram_addr(`SLAVE_BOOT, n), '0, '0);
      finish_test("test 3 boot remap");

      for (int n = 0; n < 2; n++) begin
         boot_bit = (n == 0) ? 1'($urandom) : 1'b1;
         pulse_cycles = 0;
         bus_op(RST_ADDR, data_t'({boot_bit, 1'b1}), 4'hf, rd, lat);
         boot_flag = boot_bit;
         repeat (2) @(negedge clk);
         compare_word("test 4 pulse cycles", 1, pulse_cycles);
         check_boot("test 4 boot flag");
      end
      finish_test("test 4 core reset pulse");

      base = frames_done;
      for (int n = 0; n < N_UART; n++) begin
         tx_byte = 8'($urandom);
         exp_bytes.push_back(tx_byte);
         bus_op(UART_DATA, data_t'(tx_byte), 4'h1, rd, lat);
         if (n == 0) begin
            bus_op(UART_STAT, '0, '0, rd, lat);
            compare_word("test 5 busy during frame", 1, rd & 1);
         end
      end
      while (frames_done < base + N_UART) @(negedge clk);
      repeat (BIT) @(negedge clk);
      bus_op(UART_STAT, '0, '0, rd, lat);
      compare_word("test 5 busy when idle", 0, rd & 1);
      assert (exp_bytes.size() == 0)
         else note_failure("test 5: some written bytes were never sent");
      finish_test("test 5 uart frames");

      base = frames_done;
      @(negedge clk);
      uart_cts = 1'b0;
      tx_byte = 8'($urandom);
      tx_byte2 = 8'($urandom);
      exp_bytes.push_back(tx_byte);
      exp_bytes.push_back(tx_byte2);
      bus_op(UART_DATA, data_t'(tx_byte), 4'h1, rd, lat);
      compare_word("test 6 first write latency", 1, lat);
      drive_req(UART_DATA, data_t'(tx_byte2), 4'h1);
      repeat (HOLD) begin
         @(negedge clk);
         assert (rsp.ready === 1'b0 && uart_txd === 1'b1)
            else note_failure("test 6: uart acknowledged or sent while cts was low");
      end
      uart_cts = 1'b1;
      wait_ready(rd, lat);
      compare_word("test 6 frames before second ready", base + 1, frames_done);
      while (frames_done < base + 2) @(negedge clk);
      assert (exp_bytes.size() == 0)
         else note_failure("test 6: held bytes were never sent");
      finish_test("test 6 cts flow control");

      $display("tests run: 6, tests failed: %0d, failed checks: %0d", tests_failed, errors);
      if (errors == 0) begin
         $display("*** TEST PASSED ***");
      end else begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+include
source/soc_pkg.sv
source/soc_interconnect.sv
source/soc_ram.sv
source/soc_uart_tx.sv
source/soc_reset_ctrl.sv
source/soc_system.sv
testbench/tb_soc_system.sv
